// File: fraise_map_pkg.sv
// fraise bus map
// bus word types, register byte addresses and the decoded register select
package fraise_map_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int HOST_W = 1;  // two initiators on the bus

    typedef logic [DATA_W-1:0] data_w_t;
    typedef logic [ADDR_W-1:0] addr_w_t;
    typedef logic [HOST_W-1:0] host_id_t;

    // word spaced register window from 0x10
    localparam addr_w_t REG_BASE    = 32'h0000_0010;
    localparam addr_w_t REG_ON_OFF  = REG_BASE + 32'h00;
    localparam addr_w_t REG_LAUNCH  = REG_BASE + 32'h04;
    localparam addr_w_t REG_STATUS  = REG_BASE + 32'h08;
    localparam addr_w_t REG_RESULT  = REG_BASE + 32'h0C;
    localparam addr_w_t REG_OBS_COL = REG_BASE + 32'h14;
    localparam addr_w_t REG_OBS_ROW = REG_BASE + 32'h18;

    typedef struct packed {
        logic on_off;
        logic launch;
        logic status;
        logic result;
        logic obs_col;
        logic obs_row;
    } reg_sel_t;

    typedef struct packed {
        logic     valid;
        logic     wen;    // 1 for write
        host_id_t host;
        addr_w_t  addr;
        data_w_t  wdata;
    } bus_req_t;

    typedef struct packed {
        logic     valid;
        host_id_t host;   // echoed from the request
        data_w_t  data;
    } bus_resp_t;

endpackage

// File: fraise_array_pkg.sv
// fraise array side definitions
// lane geometry, read sequence timing, array control bundle and inference states
package fraise_array_pkg;

    localparam int LANES       = 4;  // likelihood matrices
    localparam int READ_PHASES = 4;  // pulse phases per lane read
    localparam int INF_WAIT    = 4;
    localparam int OUT_WAIT    = 4;
    localparam int OUT_BITS    = 8;  // serial bits per lane result

    typedef logic [$clog2(LANES)-1:0] lane_idx_t;
    typedef logic [2:0] obs_col_t;
    typedef logic [5:0] obs_row_t;
    typedef logic [7:0] array_addr_t;
    typedef logic [7:0] result_byte_t;
    typedef logic [3:0] phase_t;

    // control lines into the memory array
    typedef struct packed {
        logic        csl;        // source line
        logic        cwl;        // word line
        logic        read_8;
        logic        inference;
        logic        read_out;
        logic        stoch_log;  // log mode while a run is active
        array_addr_t addr_col;
        array_addr_t addr_row;
    } array_ctrl_t;

    typedef enum logic [2:0] {
        Idle,
        Read_cycles,
        Inf_cycles,
        Read_out,
        Run_log,
        Done
    } infer_state_e;

endpackage

// File: fraise_reg_bank.sv
`timescale 1ns/1ns
// fraise register bank
// decodes bus requests, holds control and observation words, returns one-cycle responses
module fraise_reg_bank
    import fraise_map_pkg::*, fraise_array_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     counter_read_reset,
    input  bus_req_t                 req_i,
    input  logic                     busy_i,
    input  logic                     done_i,
    input  result_byte_t [LANES-1:0] results_i,
    output logic                     ready_o,
    output bus_resp_t                resp_o,
    output logic                     run_o,
    output obs_col_t [LANES-1:0]     obs_col_o,
    output obs_row_t [LANES-1:0]     obs_row_o
);

    data_w_t  on_off_q;
    logic     launch_q;
    logic     done_q;
    data_w_t  obs_col_q;
    data_w_t  obs_row_q;
    reg_sel_t sel;
    logic     accept;
    data_w_t  rdata;

    assign run_o   = (on_off_q == data_w_t'(1)) && launch_q;
    assign ready_o = !(busy_i || run_o);  // run_o covers the cycle before busy rises
    assign accept  = req_i.valid && ready_o;

    always_comb begin
        sel = '0;
        case (req_i.addr)
            REG_ON_OFF:  sel.on_off = 1'b1;
            REG_LAUNCH:  sel.launch = 1'b1;
            REG_STATUS:  sel.status = 1'b1;
            REG_RESULT:  sel.result = 1'b1;
            REG_OBS_COL: sel.obs_col = 1'b1;
            REG_OBS_ROW: sel.obs_row = 1'b1;
            default:     sel = '0;  // unmapped reads return zero
        endcase
    end

    // response word carries the new value on a write
    always_comb begin
        rdata = '0;
        if (sel.on_off) begin
            rdata = req_i.wen ? req_i.wdata : on_off_q;
        end else if (sel.launch) begin
            rdata = req_i.wen ? data_w_t'(req_i.wdata[0]) : data_w_t'(launch_q);
        end else if (sel.status) begin
            rdata = data_w_t'(done_q);
        end else if (sel.result) begin
            rdata = results_i;  // lane i in byte i
        end else if (sel.obs_col) begin
            rdata = req_i.wen ? req_i.wdata : obs_col_q;
        end else if (sel.obs_row) begin
            rdata = req_i.wen ? req_i.wdata : obs_row_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            on_off_q     <= '0;
            launch_q     <= 1'b0;
            done_q       <= 1'b0;
            obs_col_q    <= '0;
            obs_row_q    <= '0;
            resp_o.valid <= 1'b0;
        end else begin
            resp_o.valid <= accept;
            if (accept && req_i.wen) begin
                if (sel.on_off) on_off_q <= req_i.wdata;
                if (sel.obs_col) obs_col_q <= req_i.wdata;
                if (sel.obs_row) obs_row_q <= req_i.wdata;
                if (sel.launch) begin
                    launch_q <= req_i.wdata[0];
                    done_q   <= 1'b0;
                end
            end
            if (done_i) begin  // a finished run turns the bank back off
                on_off_q <= '0;
                launch_q <= 1'b0;
                done_q   <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            resp_o.host <= req_i.host;
            resp_o.data <= rdata;
        end
    end

    // byte j of each observation word feeds lane j
    always_comb begin
        for (int j = 0; j < LANES; j++) begin
            obs_col_o[j] = obs_col_q[8*j +: $bits(obs_col_t)];
            obs_row_o[j] = obs_row_q[8*j +: $bits(obs_row_t)];
        end
    end

endmodule

// File: fraise_infer_fsm.sv
`timescale 1ns/1ns
// fraise inference sequencer
// walks the lane reads, then the inference wait, read-out wait and serial capture
module fraise_infer_fsm
    import fraise_array_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 counter_read_reset,
    input  logic                 run_i,
    input  obs_col_t [LANES-1:0] obs_col_i,
    input  obs_row_t [LANES-1:0] obs_row_i,
    input  phase_t               phase_i,
    output logic                 phase_clr_o,
    output logic                 phase_en_o,
    output array_ctrl_t          array_ctrl_o,
    output logic                 capture_o,
    output logic [2:0]           cap_index_o,
    output logic                 clear_o,
    output logic                 busy_o,
    output logic                 done_o
);

    infer_state_e state_q;
    infer_state_e state_d;
    lane_idx_t    lane_q;
    logic         win_end;  // last cycle of the current phase window

    always_comb begin
        state_d = state_q;
        win_end = 1'b0;
        case (state_q)
            Idle: begin
                if (run_i) state_d = Read_cycles;
            end
            Read_cycles: begin
                if (phase_i == phase_t'(READ_PHASES - 1)) begin
                    win_end = 1'b1;
                    if (lane_q == lane_idx_t'(LANES - 1)) state_d = Inf_cycles;
                end
            end
            Inf_cycles: begin
                if (phase_i == phase_t'(INF_WAIT - 1)) begin
                    win_end = 1'b1;
                    state_d = Read_out;
                end
            end
            Read_out: begin
                if (phase_i == phase_t'(OUT_WAIT - 1)) begin
                    win_end = 1'b1;
                    state_d = Run_log;
                end
            end
            Run_log: begin
                if (phase_i == phase_t'(OUT_BITS - 1)) begin
                    win_end = 1'b1;
                    state_d = Done;
                end
            end
            default: state_d = Idle;  // Done lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            state_q <= Idle;
            lane_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == Idle) begin
                lane_q <= '0;
            end else if (state_q == Read_cycles && win_end) begin
                lane_q <= lane_q + 1'b1;  // wraps to 0 after the last lane
            end
        end
    end

    assign busy_o      = (state_q != Idle);
    assign done_o      = (state_q == Done);
    assign clear_o     = (state_q == Idle) && run_i;
    assign phase_en_o  = busy_o;
    assign phase_clr_o = (state_q == Idle) || (state_q == Done) || win_end;
    assign capture_o   = (state_q == Run_log);
    assign cap_index_o = phase_i[2:0];

    always_comb begin
        array_ctrl_o           = '0;
        array_ctrl_o.stoch_log = busy_o;
        case (state_q)
            Read_cycles: begin
                array_ctrl_o.read_8   = 1'b1;
                array_ctrl_o.csl      = (phase_i == '0);  // drops after phase 0
                array_ctrl_o.cwl      = (phase_i != phase_t'(READ_PHASES - 1));
                array_ctrl_o.addr_col = {lane_q, 3'b000, obs_col_i[lane_q]};
                array_ctrl_o.addr_row = {2'b00, obs_row_i[lane_q]};
            end
            Inf_cycles: array_ctrl_o.inference = 1'b1;
            Read_out:   array_ctrl_o.read_out = 1'b1;
            Run_log:    array_ctrl_o.read_out = 1'b1;
            default:    array_ctrl_o.read_out = 1'b0;
        endcase
    end

endmodule

// File: fraise_phase_counter.sv
`timescale 1ns/1ns
// fraise phase counter
// times pulse phases, wait windows and capture cycles
module fraise_phase_counter
    import fraise_array_pkg::*;
(
    input  logic   clk_i,
    input  logic   counter_read_reset,
    input  logic   clr_i,
    input  logic   en_i,
    output phase_t count_o
);

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            count_o <= '0;
        end else if (clr_i) begin  // clear wins over enable
            count_o <= '0;
        end else if (en_i) begin
            count_o <= count_o + 1'b1;
        end
    end

endmodule

// File: fraise_result_asm.sv
`timescale 1ns/1ns
// fraise result assembler
// shifts each lane's serial bit_out into its result byte, msb first
module fraise_result_asm
    import fraise_array_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     counter_read_reset,
    input  logic                     clear_i,
    input  logic                     capture_i,
    input  logic [2:0]               cap_index_i,
    input  logic [LANES-1:0]         bit_out_i,
    output result_byte_t [LANES-1:0] results_o
);

    always_ff @(posedge clk_i) begin
        if (counter_read_reset) begin
            results_o <= '0;
        end else if (clear_i) begin
            results_o <= '0;  // new run starting
        end else if (capture_i) begin
            for (int i = 0; i < LANES; i++) begin
                // capture k lands in bit 7-k
                results_o[i][3'd7 - cap_index_i] <= bit_out_i[i];
            end
        end
    end

endmodule

// File: fraise_top.sv
`timescale 1ns/1ns
// fraise inference controller top
// register bank, sequencer, phase counter and result assembler around the array
module fraise_top
    import fraise_map_pkg::*, fraise_array_pkg::*;
(
    input  logic             clk_i,
    input  logic             counter_read_reset,
    input  logic             req_valid_i,
    input  host_id_t         req_host_addr_i,
    input  addr_w_t          req_addr_i,
    input  logic             req_wen_i,
    input  data_w_t          req_wdata_i,
    input  logic [LANES-1:0] bit_out_i,      // serial outputs of the array
    output logic             ready_o,
    output logic             resp_valid_o,
    output data_w_t          resp_data_o,
    output host_id_t         resp_ini_addr_o,
    output array_ctrl_t      array_ctrl_o
);

    bus_req_t                 req;
    bus_resp_t                resp;
    logic                     run;
    logic                     busy;
    logic                     done;
    obs_col_t [LANES-1:0]     obs_col;
    obs_row_t [LANES-1:0]     obs_row;
    result_byte_t [LANES-1:0] results;
    phase_t                   phase;
    logic                     phase_clr;
    logic                     phase_en;
    logic                     capture;
    logic [2:0]               cap_index;
    logic                     res_clear;

    assign req.valid = req_valid_i;
    assign req.wen   = req_wen_i;
    assign req.host  = req_host_addr_i;
    assign req.addr  = req_addr_i;
    assign req.wdata = req_wdata_i;

    assign resp_valid_o    = resp.valid;
    assign resp_data_o     = resp.data;
    assign resp_ini_addr_o = resp.host;

    fraise_reg_bank u_reg_bank (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .req_i              (req),
        .busy_i             (busy),
        .done_i             (done),
        .results_i          (results),
        .ready_o            (ready_o),
        .resp_o             (resp),
        .run_o              (run),
        .obs_col_o          (obs_col),
        .obs_row_o          (obs_row)
    );

    fraise_infer_fsm u_infer_fsm (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .run_i              (run),
        .obs_col_i          (obs_col),
        .obs_row_i          (obs_row),
        .phase_i            (phase),
        .phase_clr_o        (phase_clr),
        .phase_en_o         (phase_en),
        .array_ctrl_o       (array_ctrl_o),
        .capture_o          (capture),
        .cap_index_o        (cap_index),
        .clear_o            (res_clear),
        .busy_o             (busy),
        .done_o             (done)
    );

    fraise_phase_counter u_phase_counter (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .clr_i              (phase_clr),
        .en_i               (phase_en),
        .count_o            (phase)
    );

    fraise_result_asm u_result_asm (
        .clk_i              (clk_i),
        .counter_read_reset (counter_read_reset),
        .clear_i            (res_clear),
        .capture_i          (capture),
        .cap_index_i        (cap_index),
        .bit_out_i          (bit_out_i),
        .results_o          (results)
    );

endmodule

// File: fraise_checker.sv
`timescale 1ns/1ns
// fraise checker
// watches the DUT ports, keeps a register model and compares responses and array controls
module fraise_checker
    import fraise_map_pkg::*, fraise_array_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     counter_read_reset,
    input  logic                     req_valid_i,
    input  host_id_t                 req_host_i,
    input  addr_w_t                  req_addr_i,
    input  logic                     req_wen_i,
    input  data_w_t                  req_wdata_i,
    input  logic                     ready_i,
    input  logic                     resp_valid_i,
    input  data_w_t                  resp_data_i,
    input  host_id_t                 resp_host_i,
    input  array_ctrl_t              array_ctrl_i,
    input  result_byte_t [LANES-1:0] drive_bytes_i,  // bytes the array model shifts out
    output int                       err_count_o
);

    // launch cycle, lane reads, inference, read-out wait, capture, done
    localparam int RUN_CYCLES = 1 + LANES * READ_PHASES + INF_WAIT + OUT_WAIT + OUT_BITS + 1;

    string    test_name = "";
    data_w_t  on_off_m;
    logic     launch_m;
    logic     done_m;
    data_w_t  obs_col_m;
    data_w_t  obs_row_m;
    data_w_t  result_m;
    int       busy_left;  // cycles until ready returns
    logic     resp_pend;
    host_id_t exp_host;
    data_w_t  exp_data;

    initial err_count_o = 0;

    // expected response word for a request at the current model state
    function automatic data_w_t reg_readback(addr_w_t addr, logic wen, data_w_t wdata);
        case (addr)
            REG_ON_OFF:  return wen ? wdata : on_off_m;
            REG_LAUNCH:  return wen ? data_w_t'(wdata[0]) : data_w_t'(launch_m);
            REG_STATUS:  return data_w_t'(done_m);
            REG_RESULT:  return result_m;
            REG_OBS_COL: return wen ? wdata : obs_col_m;
            REG_OBS_ROW: return wen ? wdata : obs_row_m;
            default:     return '0;
        endcase
    endfunction

    // expected array controls for a given point in the run
    function automatic array_ctrl_t expected_ctrl(int left, data_w_t col_w, data_w_t row_w);
        array_ctrl_t c;
        int          step;
        int          lane;
        int          ph;
        c = '0;
        step = RUN_CYCLES - left;  // 1 is the first lane read cycle
        if (left == 0 || left == RUN_CYCLES) return c;
        c.stoch_log = 1'b1;
        if (step <= LANES * READ_PHASES) begin
            lane = (step - 1) / READ_PHASES;
            ph = (step - 1) % READ_PHASES;
            c.read_8 = 1'b1;
            c.csl = (ph == 0);
            c.cwl = (ph != READ_PHASES - 1);
            c.addr_col = {lane[1:0], 3'b000, col_w[8*lane +: 3]};
            c.addr_row = {2'b00, row_w[8*lane +: 6]};
        end else if (step <= LANES * READ_PHASES + INF_WAIT) begin
            c.inference = 1'b1;
        end else if (step < RUN_CYCLES - 1) begin
            c.read_out = 1'b1;
        end
        return c;
    endfunction

    task automatic report_value(string what, data_w_t exp, data_w_t act);
        $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        err_count_o++;
    endtask

    task automatic report_text(string msg);
        $display("ERROR in %s: %s", test_name, msg);
        err_count_o++;
    endtask

    // samples the pre-edge values while inputs move 2 ns after the edge
    always @(posedge clk_i) begin
        array_ctrl_t ctrl_exp;
        logic        accept;
        if (counter_read_reset) begin
            on_off_m  = '0;
            launch_m  = 1'b0;
            done_m    = 1'b0;
            obs_col_m = '0;
            obs_row_m = '0;
            result_m  = '0;
            busy_left = 0;
            resp_pend = 1'b0;
        end else begin
            if (resp_pend) begin
                if (!resp_valid_i) begin
                    report_text("no response one cycle after an accepted request");
                end else begin
                    if (resp_host_i !== exp_host)
                        report_value("resp host", data_w_t'(exp_host), data_w_t'(resp_host_i));
                    if (resp_data_i !== exp_data)
                        report_value("resp data", exp_data, resp_data_i);
                end
            end else if (resp_valid_i) begin
                report_text("response valid without an accepted request");
            end
            if (ready_i !== (busy_left == 0))
                report_value("ready_o", data_w_t'(busy_left == 0), data_w_t'(ready_i));
            ctrl_exp = expected_ctrl(busy_left, obs_col_m, obs_row_m);
            if (array_ctrl_i !== ctrl_exp)
                report_value("array_ctrl_o", data_w_t'(ctrl_exp), data_w_t'(array_ctrl_i));

            accept = req_valid_i && ready_i;
            resp_pend = accept;
            if (accept) begin
                exp_host = req_host_i;
                exp_data = reg_readback(req_addr_i, req_wen_i, req_wdata_i);
            end
            if (accept && req_wen_i) begin
                case (req_addr_i)
                    REG_ON_OFF:  on_off_m = req_wdata_i;
                    REG_OBS_COL: obs_col_m = req_wdata_i;
                    REG_OBS_ROW: obs_row_m = req_wdata_i;
                    REG_LAUNCH: begin
                        launch_m = req_wdata_i[0];
                        done_m   = 1'b0;
                    end
                    default: ;
                endcase
            end
            if (busy_left > 0) begin
                busy_left--;
                if (busy_left == 0) begin  // run done
                    on_off_m = '0;
                    launch_m = 1'b0;
                    done_m   = 1'b1;
                    result_m = drive_bytes_i;
                end
            end else if (on_off_m == data_w_t'(1) && launch_m) begin
                busy_left = RUN_CYCLES;
            end
        end
    end

endmodule

// File: fraise_tb.sv
`timescale 1ns/1ns
// fraise testbench
// bus tasks, serial array model and the test sequence around the controller
module fraise_tb
    import fraise_map_pkg::*, fraise_array_pkg::*;
();

    localparam int TIMEOUT = 6 * 60 + 200;

    logic                     clk = 1'b0;
    logic                     counter_read_reset;
    logic                     req_valid;
    host_id_t                 req_host;
    addr_w_t                  req_addr;
    logic                     req_wen;
    data_w_t                  req_wdata;
    logic [LANES-1:0]         bit_out;
    logic                     ready;
    logic                     resp_valid;
    data_w_t                  resp_data;
    host_id_t                 resp_host;
    array_ctrl_t              array_ctrl;
    result_byte_t [LANES-1:0] drive_bytes;
    int                       err_count;
    int                       seed = 17730;
    int                       cycles = 0;
    int                       ro_cnt = 0;
    int                       tests = 0;
    int                       failed = 0;
    int                       err_base = 0;

    always #10 clk = !clk;

    fraise_top dut (
        .clk_i              (clk),
        .counter_read_reset (counter_read_reset),
        .req_valid_i        (req_valid),
        .req_host_addr_i    (req_host),
        .req_addr_i         (req_addr),
        .req_wen_i          (req_wen),
        .req_wdata_i        (req_wdata),
        .bit_out_i          (bit_out),
        .ready_o            (ready),
        .resp_valid_o       (resp_valid),
        .resp_data_o        (resp_data),
        .resp_ini_addr_o    (resp_host),
        .array_ctrl_o       (array_ctrl)
    );

    fraise_checker chk (
        .clk_i              (clk),
        .counter_read_reset (counter_read_reset),
        .req_valid_i        (req_valid),
        .req_host_i         (req_host),
        .req_addr_i         (req_addr),
        .req_wen_i          (req_wen),
        .req_wdata_i        (req_wdata),
        .ready_i            (ready),
        .resp_valid_i       (resp_valid),
        .resp_data_i        (resp_data),
        .resp_host_i        (resp_host),
        .array_ctrl_i       (array_ctrl),
        .drive_bytes_i      (drive_bytes),
        .err_count_o        (err_count)
    );

    // array model shifts out bit 7-k for capture k after the 4 wait cycles
    always @(posedge clk) begin
        #2;
        ro_cnt = array_ctrl.read_out ? ro_cnt + 1 : 0;
        for (int i = 0; i < LANES; i++) begin
            bit_out[i] = (ro_cnt > OUT_WAIT) ? drive_bytes[i][7 - (ro_cnt - 1 - OUT_WAIT)] : 1'b0;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic bus_access(input logic wen, input addr_w_t addr, input data_w_t data);
        @(posedge clk);
        #2;
        while (!ready) begin
            @(posedge clk);
            #2;
        end
        req_valid = 1'b1;
        req_wen   = wen;
        req_addr  = addr;
        req_wdata = data;
        req_host  = host_id_t'($random(seed));
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic wait_run_done();
        @(posedge clk);
        #2;
        while (!ready) begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic start_test(input string name);
        chk.test_name = name;
        err_base = err_count;
    endtask

    task automatic end_test();
        @(posedge clk);  // last response is checked on this edge
        #1;
        tests++;
        if (err_count != err_base) failed++;
        $display("test %s: %s", chk.test_name, (err_count == err_base) ? "ok" : "errors");
    endtask

    task automatic launch_run();
        data_w_t col_w;
        data_w_t row_w;
        col_w = $random(seed);
        row_w = $random(seed);
        drive_bytes = $random(seed);
        bus_access(1'b1, REG_OBS_COL, col_w);
        bus_access(1'b1, REG_OBS_ROW, row_w);
        bus_access(1'b1, REG_ON_OFF, 32'd1);
        bus_access(1'b1, REG_LAUNCH, 32'd1);
        wait_run_done();
        bus_access(1'b0, REG_RESULT, '0);
        bus_access(1'b0, REG_STATUS, '0);
    endtask

    initial begin
        counter_read_reset = 1'b1;
        req_valid = 1'b0;
        req_host  = '0;
        req_addr  = '0;
        req_wen   = 1'b0;
        req_wdata = '0;
        bit_out   = '0;
        drive_bytes = '0;
        repeat (8) @(posedge clk);
        #2;
        counter_read_reset = 1'b0;

        start_test("reset_state");
        bus_access(1'b0, REG_STATUS, '0);
        end_test();

        start_test("register_readback");
        bus_access(1'b1, REG_OBS_COL, $random(seed));
        bus_access(1'b1, REG_OBS_ROW, $random(seed));
        bus_access(1'b1, REG_ON_OFF, 32'h0000_0a00 | $random(seed));
        bus_access(1'b0, REG_OBS_COL, '0);
        bus_access(1'b0, REG_OBS_ROW, '0);
        bus_access(1'b0, REG_ON_OFF, '0);
        bus_access(1'b1, REG_ON_OFF, 32'd0);
        end_test();

        start_test("single_run");
        launch_run();
        end_test();

        start_test("launch_while_off");
        bus_access(1'b1, REG_LAUNCH, 32'd1);
        repeat (10) @(posedge clk);
        bus_access(1'b0, REG_STATUS, '0);
        bus_access(1'b1, REG_LAUNCH, 32'd0);
        end_test();

        start_test("back_to_back_runs");
        for (int r = 0; r < 4; r++) launch_run();
        end_test();

        repeat (2) @(posedge clk);
        $display("tests: %0d, failed: %0d, check errors: %0d", tests, failed, err_count);
        if (failed == 0 && err_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: fraise_top.f
fraise_map_pkg.sv
fraise_array_pkg.sv
fraise_reg_bank.sv
fraise_infer_fsm.sv
fraise_phase_counter.sv
fraise_result_asm.sv
fraise_top.sv
fraise_checker.sv
fraise_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the fraise testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module fraise_tb -f fraise_top.f

output=$(./obj_dir/Vfraise_tb)
echo "$output"

echo "$output" | grep -q "Finished with no errors"
